// File: design/av_pkg.sv
// types and constants shared by the video and audio paths
// everything is in the single audgen_mclk domain
// coord_t is 10 bits, so a raster total of 1024 is held as 0 and
// the counters wrap modulo 1024

`default_nettype none

package av_pkg;

    //////////////////////////////////////////////////////////////////////
    // video
    //////////////////////////////////////////////////////////////////////

    // raster counter value, x or y
    typedef logic [9:0] coord_t;

    // one colour component from the pixel source
    typedef logic [3:0] nibble_t;

    // output colour, red in the top byte
    typedef logic [23:0] rgb24_t;

    // answer of the pixel source, 12 bits
    typedef struct packed {
        nibble_t r;
        nibble_t g;
        nibble_t b;
    } pixel_rgb4_t;

    // raster control levels and pulses for one clock
    typedef struct packed {
        logic de;
        logic vs;
        logic hs;
    } vid_timing_t;

    // hs lands this many clocks after the line start
    localparam int unsigned HS_DELAY = 3;

    //////////////////////////////////////////////////////////////////////
    // audio
    //////////////////////////////////////////////////////////////////////

    typedef logic signed [15:0] sample_t;

    // left channel in the upper half
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_sample_t;

    localparam int unsigned I2S_SLOT_BITS = 32;
    localparam int unsigned I2S_DATA_BITS = 16;
    // mclk / 4 gives sclk
    localparam int unsigned SCLK_DIV_BITS = 2;

endpackage

`default_nettype wire

// File: design/video_timing.sv
// raster counters and sync decode for the pixel clock (audgen_mclk)
// the back porches must be nonzero so vs never meets the active window
// H_TOTAL must exceed HS_DELAY; totals are taken modulo 1024

`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter av_pkg::coord_t H_TOTAL  = av_pkg::coord_t'(800),
    parameter av_pkg::coord_t H_ACTIVE = av_pkg::coord_t'(400),
    parameter av_pkg::coord_t H_BPORCH = av_pkg::coord_t'(10),
    parameter av_pkg::coord_t V_TOTAL  = av_pkg::coord_t'(1024),
    parameter av_pkg::coord_t V_ACTIVE = av_pkg::coord_t'(360),
    parameter av_pkg::coord_t V_BPORCH = av_pkg::coord_t'(10)
) (
    input  logic                audgen_mclk,
    input  logic                reset_n,
    output logic                pixel_req,
    output av_pkg::vid_timing_t timing
);
    import av_pkg::*;

    // last counter values, wrap is modulo the coord_t width
    localparam coord_t H_LAST = coord_t'(H_TOTAL - coord_t'(1));
    localparam coord_t V_LAST = coord_t'(V_TOTAL - coord_t'(1));
    // first column and row past the active window
    localparam coord_t H_END  = coord_t'(H_BPORCH + H_ACTIVE);
    localparam coord_t V_END  = coord_t'(V_BPORCH + V_ACTIVE);
    localparam coord_t HS_X   = coord_t'(HS_DELAY);

    coord_t x_cnt;
    coord_t y_cnt;
    logic   h_active;
    logic   v_active;
    logic   frame_start;
    logic   line_hs;

    //////////////////////////////////////////////////////////////////////
    // raster position
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (x_cnt == H_LAST) begin
            x_cnt <= '0;
            // y steps once per line
            if (y_cnt == V_LAST) begin
                y_cnt <= '0;
            end else begin
                y_cnt <= y_cnt + 1'b1;
            end
        end else begin
            x_cnt <= x_cnt + 1'b1;
        end
    end

    // active window, after the back porch
    assign h_active = (x_cnt >= H_BPORCH) && (x_cnt < H_END);
    assign v_active = (y_cnt >= V_BPORCH) && (y_cnt < V_END);

    // source gets the request in the same clock as the position
    assign pixel_req = h_active && v_active;

    assign frame_start = (x_cnt == '0) && (y_cnt == '0);
    // hs kept off the vs clock, a few columns later
    assign line_hs     = (x_cnt == HS_X);

    //////////////////////////////////////////////////////////////////////
    // registered controls, one clock behind the counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            timing <= '0;
        end else begin
            timing.de <= pixel_req;
            timing.vs <= frame_start;
            timing.hs <= line_hs;
        end
    end

    // vs stands alone in its clock
    a_vs_alone: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        timing.vs |-> !(timing.hs || timing.de));

    a_cnt_range: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        (x_cnt <= H_LAST) && (y_cnt <= V_LAST));

endmodule

`default_nettype wire

// File: design/video_pixel_out.sv
// second video stage: source pixel capture and 24-bit expansion
// pixel_in must be valid in the clock after pixel_req, no back-pressure
// outputs are two clocks behind the raster counters

`timescale 1ns/1ps
`default_nettype none

module video_pixel_out (
    input  logic                audgen_mclk,
    input  logic                reset_n,
    input  av_pkg::vid_timing_t timing,
    input  av_pkg::pixel_rgb4_t pixel_in,
    output av_pkg::rgb24_t      video_rgb,
    output logic                video_de,
    output logic                video_vs,
    output logic                video_hs
);
    import av_pkg::*;

    rgb24_t rgb_wide;

    // nibble into the top of each byte, low nibbles zero
    assign rgb_wide = {pixel_in.r, 4'h0,
                       pixel_in.g, 4'h0,
                       pixel_in.b, 4'h0};

    //////////////////////////////////////////////////////////////////////
    // output stage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            video_de  <= 1'b0;
            video_vs  <= 1'b0;
            video_hs  <= 1'b0;
            video_rgb <= '0;
        end else begin
            // controls delayed once more to meet the pixel
            video_de <= timing.de;
            video_vs <= timing.vs;
            video_hs <= timing.hs;
            // blanking is black
            if (timing.de) begin
                video_rgb <= rgb_wide;
            end else begin
                video_rgb <= '0;
            end
        end
    end

    // colour only shows inside the window
    a_blank_black: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        !video_de |-> (video_rgb == '0));

endmodule

`default_nettype wire

// File: design/i2s_serializer.sv
// i2s transmitter, sclk = mclk / 4, 32 bit slots, lrck low is left
// 16 sample bits MSB first after the one-bit delay, rest of slot zero
// the pair is latched whole where lrck goes from right to left
// the first left slot after reset sends zeros

`timescale 1ns/1ps
`default_nettype none

module i2s_serializer (
    input  logic                   audgen_mclk,
    input  logic                   reset_n,
    input  av_pkg::stereo_sample_t sample,
    output logic                   audio_sclk,
    output logic                   audio_lrck,
    output logic                   audio_dac
);
    import av_pkg::*;

    localparam int unsigned CNT_W = $clog2(I2S_SLOT_BITS);

    typedef logic [CNT_W-1:0] slot_cnt_t;

    localparam slot_cnt_t SLOT_LAST = slot_cnt_t'(I2S_SLOT_BITS - 1);
    localparam slot_cnt_t DATA_END  = slot_cnt_t'(I2S_DATA_BITS);

    logic [SCLK_DIV_BITS-1:0] div_q;
    logic                     sclk_fall;
    logic                     slot_end;
    slot_cnt_t                bit_cnt;
    sample_t                  shift_q;
    // right half held until its slot
    sample_t                  right_q;

    //////////////////////////////////////////////////////////////////////
    // bit clock
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    assign audio_sclk = div_q[SCLK_DIV_BITS-1];
    // divider about to wrap, sclk drops at this edge
    assign sclk_fall  = &div_q;
    assign slot_end   = sclk_fall && (bit_cnt == SLOT_LAST);

    //////////////////////////////////////////////////////////////////////
    // slot counter and word select
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt    <= '0;
            audio_lrck <= 1'b0;
        end else if (slot_end) begin
            bit_cnt    <= '0;
            audio_lrck <= ~audio_lrck;
        end else if (sclk_fall) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // data shifter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge audgen_mclk or negedge reset_n) begin
        if (!reset_n) begin
            shift_q   <= '0;
            right_q   <= '0;
            audio_dac <= 1'b0;
        end else if (slot_end) begin
            // delay bit together with the lrck change
            audio_dac <= 1'b0;
            if (audio_lrck) begin
                // right to left, take a new pair
                shift_q <= sample.left;
                right_q <= sample.right;
            end else begin
                shift_q <= right_q;
            end
        end else if (sclk_fall) begin
            if (bit_cnt < DATA_END) begin
                audio_dac <= shift_q[$bits(sample_t)-1];
                shift_q   <= {shift_q[$bits(sample_t)-2:0], 1'b0};
            end else begin
                // padding to the end of the slot
                audio_dac <= 1'b0;
            end
        end
    end

    // word select and data only move as sclk falls
    a_lrck_on_fall: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_lrck) |-> $fell(audio_sclk));

    a_dac_on_fall: assert property (@(posedge audgen_mclk) disable iff (!reset_n)
        $changed(audio_dac) |-> $fell(audio_sclk));

endmodule

`default_nettype wire

// File: design/av_core_top.sv
// audio/video output core, all in the 12.288 MHz audgen_mclk domain
// mclk is both pixel clock and i2s master clock
// pixel source answers each pixel_req in the following clock
// the sample pair is a held level, taken at each left slot start

`timescale 1ns/1ps
`default_nettype none

module av_core_top #(
    parameter av_pkg::coord_t H_TOTAL  = av_pkg::coord_t'(800),
    parameter av_pkg::coord_t H_ACTIVE = av_pkg::coord_t'(400),
    parameter av_pkg::coord_t H_BPORCH = av_pkg::coord_t'(10),
    parameter av_pkg::coord_t V_TOTAL  = av_pkg::coord_t'(1024),
    parameter av_pkg::coord_t V_ACTIVE = av_pkg::coord_t'(360),
    parameter av_pkg::coord_t V_BPORCH = av_pkg::coord_t'(10)
) (
    input  logic                   audgen_mclk,
    input  logic                   reset_n,
    // pixel source
    output logic                   pixel_req,
    input  av_pkg::pixel_rgb4_t    pixel_in,
    // video out
    output av_pkg::rgb24_t         video_rgb,
    output logic                   video_de,
    output logic                   video_vs,
    output logic                   video_hs,
    // audio
    input  av_pkg::stereo_sample_t sample,
    output logic                   audio_sclk,
    output logic                   audio_lrck,
    output logic                   audio_dac
);
    import av_pkg::*;

    // raster controls between the two video stages
    vid_timing_t timing;

    //////////////////////////////////////////////////////////////////////
    // video path
    //////////////////////////////////////////////////////////////////////

    video_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_ACTIVE (H_ACTIVE),
        .H_BPORCH (H_BPORCH),
        .V_TOTAL  (V_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_BPORCH (V_BPORCH)
    ) timing_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pixel_req   (pixel_req),
        .timing      (timing)
    );

    video_pixel_out pixel_out_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .timing      (timing),
        .pixel_in    (pixel_in),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_vs    (video_vs),
        .video_hs    (video_hs)
    );

    // audio path, free running from reset
    i2s_serializer i2s_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .sample      (sample),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

endmodule

`default_nettype wire

// File: verif/av_core_tasks.svh
// directed tests, included inside the testbench module body
// each wait is a bounded loop at the falling clock edge

`ifndef AV_CORE_TASKS_SVH
`define AV_CORE_TASKS_SVH

task automatic wait_video_vs(input int limit);
    int n;
    n = 0;
    @(negedge audgen_mclk);
    while (!video_vs) begin
        n++;
        if (n > limit) report_failure("timeout waiting for video_vs");
        @(negedge audgen_mclk);
    end
endtask

task automatic wait_lrck_edge(input logic level);
    logic lrck_q;
    int   n;
    lrck_q = audio_lrck;
    n = 0;
    forever begin
        @(negedge audgen_mclk);
        if (audio_lrck == level && lrck_q != level) break;
        n++;
        if (n > 300) report_failure("timeout waiting for audio_lrck to change");
        lrck_q = audio_lrck;
    end
endtask

task automatic wait_sclk_rise();
    logic sclk_q;
    int   n;
    sclk_q = audio_sclk;
    n = 0;
    forever begin
        @(negedge audgen_mclk);
        if (audio_sclk && !sclk_q) break;
        n++;
        if (n > 8) report_failure("timeout waiting for audio_sclk to rise");
        sclk_q = audio_sclk;
    end
endtask

task automatic check_outputs_low();
    compare_value("video_rgb", video_rgb, 0);
    compare_value("{video_de,video_vs,video_hs,pixel_req}",
                  {video_de, video_vs, video_hs, pixel_req}, 0);
    compare_value("{audio_sclk,audio_lrck,audio_dac}",
                  {audio_sclk, audio_lrck, audio_dac}, 0);
endtask

////////////////////////////////////////////////////////////////////////
// video
////////////////////////////////////////////////////////////////////////

task automatic reset_values_test();
    int n;
    repeat (7) begin
        @(negedge audgen_mclk);
        check_outputs_low();
    end
    // release after the 8th rising edge
    @(posedge audgen_mclk);
    #DRIVE_DELAY;
    reset_n = 1'b1;
    @(negedge audgen_mclk);
    check_outputs_low();
    // first vs two rising edges after release
    n = 0;
    while (!video_vs) begin
        @(posedge audgen_mclk);
        @(negedge audgen_mclk);
        n++;
        if (n > 8) report_failure("timeout waiting for the first video_vs");
    end
    compare_value("clocks from reset release to video_vs", n, 2);
endtask

task automatic frame_structure_test();
    int n;
    int hs_cnt;
    int de_cnt;
    wait_video_vs(2 * FRAME_CLKS);
    n = 0;
    hs_cnt = 0;
    de_cnt = 0;
    do begin
        @(negedge audgen_mclk);
        n++;
        if (n > 2 * FRAME_CLKS) report_failure("timeout waiting for the frame end");
        // line starts every H_TOTAL clocks from vs
        compare_value("video_hs", video_hs, (n % H_TOTAL) == HS_CLKS);
        require_true(!(video_vs && (video_hs || video_de)),
                     "video_vs overlaps video_hs or video_de");
        hs_cnt += video_hs;
        de_cnt += video_de;
    end while (!video_vs);
    compare_value("clocks per frame", n, FRAME_CLKS);
    compare_value("video_hs pulses per frame", hs_cnt, V_TOTAL);
    compare_value("video_de clocks per frame", de_cnt, H_ACTIVE * V_ACTIVE);
endtask

task automatic pixel_path_test();
    int     n;
    int     req_cnt;
    int     de_cnt;
    logic   req_d1;
    logic   req_d2;
    rgb24_t exp;
    wait_video_vs(2 * FRAME_CLKS);
    // no request in flight at frame start
    pix_q.delete();
    req_d1 = pixel_req;
    req_d2 = 1'b0;
    n = 0;
    req_cnt = 0;
    de_cnt = 0;
    do begin
        @(negedge audgen_mclk);
        n++;
        if (n > 2 * FRAME_CLKS) report_failure("timeout waiting for the frame end");
        // de trails the request by two clocks
        compare_value("video_de", video_de, req_d2);
        if (video_de) begin
            require_true(pix_q.size() > 0, "video_de high with no pixel requested");
            exp = pix_q.pop_front();
            compare_value("video_rgb", video_rgb, exp);
            de_cnt++;
        end else begin
            compare_value("video_rgb", video_rgb, 0);
        end
        req_cnt += pixel_req;
        req_d2 = req_d1;
        req_d1 = pixel_req;
    end while (!video_vs);
    compare_value("pixel_req clocks per frame", req_cnt, de_cnt);
    compare_value("video_de clocks per frame", de_cnt, H_ACTIVE * V_ACTIVE);
endtask

////////////////////////////////////////////////////////////////////////
// audio
////////////////////////////////////////////////////////////////////////

task automatic audio_clock_test();
    int   last_rise;
    int   rises;
    int   toggles;
    logic sclk_q;
    logic lrck_q;
    sclk_q = audio_sclk;
    lrck_q = audio_lrck;
    last_rise = -1;
    rises = 0;
    toggles = 0;
    // three lrck frames of 256 clocks
    for (int n = 0; n < 768; n++) begin
        @(negedge audgen_mclk);
        if (audio_sclk && !sclk_q) begin
            if (last_rise >= 0) compare_value("audio_sclk period", n - last_rise, 4);
            last_rise = n;
            rises++;
        end
        if (audio_lrck != lrck_q) begin
            require_true(sclk_q && !audio_sclk, "audio_lrck changed without an sclk fall");
            if (toggles > 0) compare_value("sclk periods per lrck half", rises, 32);
            rises = 0;
            toggles++;
        end
        sclk_q = audio_sclk;
        lrck_q = audio_lrck;
    end
    require_true(toggles >= 4, "audio_lrck stopped toggling");
endtask

// 32 bits of one slot as seen at rising sclk, first bit in the MSB
task automatic capture_slot(input logic lrck_exp, output logic [31:0] bits);
    bits = '0;
    for (int b = 0; b < 32; b++) begin
        wait_sclk_rise();
        compare_value("audio_lrck", audio_lrck, lrck_exp);
        bits = {bits[30:0], audio_dac};
    end
endtask

task automatic audio_data_test(input int pairs);
    stereo_sample_t pair;
    logic [31:0]    bits;
    for (int i = 0; i < pairs; i++) begin
        pair = stereo_sample_t'($random(seed));
        @(posedge audgen_mclk);
        #DRIVE_DELAY;
        sample = pair;
        // delay bit, 16 sample bits, then 15 zeros
        wait_lrck_edge(1'b0);
        capture_slot(1'b0, bits);
        compare_value("audio_dac left slot", bits, {1'b0, pair.left, 15'h0});
        wait_lrck_edge(1'b1);
        capture_slot(1'b1, bits);
        compare_value("audio_dac right slot", bits, {1'b0, pair.right, 15'h0});
    end
endtask

`endif

// File: verif/av_core_tb.sv
// testbench for av_core_top with a small raster of 40 x 24 clocks
// outputs are sampled at the falling clock edge
// inputs change 2 ns after the rising edge
// the pixel source model answers each request in the following clock

`timescale 1ns/1ps
`default_nettype none

module av_core_tb;
    import av_pkg::*;

    // small raster so that a frame runs in 960 clocks
    localparam int H_TOTAL  = 40;
    localparam int H_ACTIVE = 20;
    localparam int H_BPORCH = 4;
    localparam int V_TOTAL  = 24;
    localparam int V_ACTIVE = 12;
    localparam int V_BPORCH = 2;
    // hs offset into each line
    localparam int HS_CLKS  = 3;
    localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
    localparam time DRIVE_DELAY = 2;

    logic           audgen_mclk;
    logic           reset_n;
    logic           pixel_req;
    pixel_rgb4_t    pixel_in;
    rgb24_t         video_rgb;
    logic           video_de;
    logic           video_vs;
    logic           video_hs;
    stereo_sample_t sample;
    logic           audio_sclk;
    logic           audio_lrck;
    logic           audio_dac;

    integer         seed = 32'h3741_2952;
    // expected colours, oldest request first
    rgb24_t         pix_q[$];
    int unsigned    check_count = 0;

    //////////////////////////////////////////////////////////////////////
    // clock, DUT, pixel source
    //////////////////////////////////////////////////////////////////////

    initial begin
        audgen_mclk = 1'b0;
        forever #20 audgen_mclk = ~audgen_mclk;
    end

    av_core_top #(
        .H_TOTAL  (coord_t'(H_TOTAL)),
        .H_ACTIVE (coord_t'(H_ACTIVE)),
        .H_BPORCH (coord_t'(H_BPORCH)),
        .V_TOTAL  (coord_t'(V_TOTAL)),
        .V_ACTIVE (coord_t'(V_ACTIVE)),
        .V_BPORCH (coord_t'(V_BPORCH))
    ) dut_i (
        .audgen_mclk (audgen_mclk),
        .reset_n     (reset_n),
        .pixel_req   (pixel_req),
        .pixel_in    (pixel_in),
        .video_rgb   (video_rgb),
        .video_de    (video_de),
        .video_vs    (video_vs),
        .video_hs    (video_hs),
        .sample      (sample),
        .audio_sclk  (audio_sclk),
        .audio_lrck  (audio_lrck),
        .audio_dac   (audio_dac)
    );

    // 4-bit component n shows as n * 16 in its output byte
    function automatic rgb24_t expand_pixel(input pixel_rgb4_t p);
        return (rgb24_t'(p.r) << 20) | (rgb24_t'(p.g) << 12) | (rgb24_t'(p.b) << 4);
    endfunction

    initial begin : pixel_source
        logic        req_seen;
        pixel_rgb4_t pix;
        req_seen = 1'b0;
        pixel_in = '0;
        forever begin
            @(posedge audgen_mclk);
            #DRIVE_DELAY;
            // a new value every clock, unrequested ones must be blanked
            pix      = pixel_rgb4_t'($random(seed));
            pixel_in = pix;
            if (req_seen) begin
                pix_q.push_back(expand_pixel(pix));
            end
            req_seen = pixel_req;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        assert (got === exp)
        else report_failure($sformatf("FAIL %s: got 0x%0h, expected 0x%0h",
                                      name, got, exp));
    endtask

    task automatic require_true(input logic cond, input string what);
        check_count++;
        assert (cond === 1'b1)
        else report_failure(what);
    endtask

    `include "av_core_tasks.svh"

    initial begin
        reset_n = 1'b0;
        sample  = '0;
        reset_values_test();
        frame_structure_test();
        pixel_path_test();
        audio_clock_test();
        audio_data_test(4);
        if (check_count > 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            report_failure("no checks were run");
        end
    end

endmodule

`default_nettype wire

// File: av_core_top.f
+incdir+verif
design/av_pkg.sv
design/video_timing.sv
design/video_pixel_out.sv
design/i2s_serializer.sv
design/av_core_top.sv
verif/av_core_tb.sv

// File: Bender.yml
package:
  name: av_core

sources:
  - files:
      - design/av_pkg.sv
      - design/video_timing.sv
      - design/video_pixel_out.sv
      - design/i2s_serializer.sv
      - design/av_core_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/av_core_tb.sv
